// File: logic/sram_alloc_pkg.sv
package sram_alloc_pkg;

    localparam int NUM_BANKS  = 32;
    localparam int NUM_PORTS  = 16;
    localparam int BANK_WORDS = 1024;
    localparam int FIFO_DEPTH = 4;

    typedef logic [4:0]  bank_idx_t;
    typedef logic [3:0]  port_idx_t;
    typedef logic [8:0]  pkt_len_t;
    typedef logic [10:0] space_t;
    typedef logic [8:0]  pkt_cnt_t;
    typedef logic [7:0]  apb_addr_t;

    // candidate order used by the matcher
    typedef enum logic [1:0] {
        MODE_STATIC  = 2'd0,
        MODE_SEMI    = 2'd1,
        MODE_DYNAMIC = 2'd2
    } match_mode_t;

    // mode and threshold are sampled from CTRL when the request is pushed
    typedef struct packed {
        port_idx_t   dest_port;
        pkt_len_t    length;
        match_mode_t mode;
        logic [4:0]  threshold;
    } match_req_t;

    typedef struct packed {
        logic      found;
        logic      fast;
        bank_idx_t bank;
        port_idx_t dest_port;
    } match_result_t;

    typedef struct packed {
        space_t   free_space;
        pkt_cnt_t packet_amount;
    } bank_status_t;

    // shared by allocation (is_release low) and release (is_release high)
    typedef struct packed {
        logic      valid;
        logic      is_release;
        bank_idx_t bank;
        port_idx_t port;
        pkt_len_t  length;
    } bank_update_t;

    // CTRL    : mode [1:0], threshold [12:8]
    // REQ     : length [8:0], dest_port [19:16]
    // RESULT  : valid [31], found [30], fast [29], dest_port [11:8], bank [4:0]
    // RELEASE : length [8:0], port [19:16], bank [28:24]
    // STATUS  : overflow [0] (write clears), request FIFO empty [1]
    localparam apb_addr_t REG_CTRL    = 8'h00;
    localparam apb_addr_t REG_LOCK    = 8'h04;
    localparam apb_addr_t REG_REQ     = 8'h08;
    localparam apb_addr_t REG_RESULT  = 8'h0C;
    localparam apb_addr_t REG_RELEASE = 8'h10;
    localparam apb_addr_t REG_STATUS  = 8'h14;

endpackage

// File: logic/desc_fifo.sv
`timescale 1ns/1ps

module desc_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t   mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic       do_push;
    logic       do_pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap explicitly so DEPTH need not be a power of two
            if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)      count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

// File: logic/bank_status_table.sv
`timescale 1ns/1ps

module bank_status_table
    import sram_alloc_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  bank_idx_t    rd_bank,
    input  port_idx_t    rd_port,
    output bank_status_t rd_status,
    input  bank_update_t alloc,
    input  bank_update_t rel
);

    space_t   free_space [NUM_BANKS];
    pkt_cnt_t pkt_cnt    [NUM_BANKS][NUM_PORTS];
    space_t   free_next  [NUM_BANKS];
    pkt_cnt_t cnt_next   [NUM_BANKS][NUM_PORTS];

    // release applied first, so a release and an allocation may hit one entry
    always_comb begin
        bank_update_t cur;
        for (int b = 0; b < NUM_BANKS; b++) begin
            free_next[b] = free_space[b];
            for (int p = 0; p < NUM_PORTS; p++) begin
                cnt_next[b][p] = pkt_cnt[b][p];
            end
        end
        for (int u = 0; u < 2; u++) begin
            cur = (u == 0) ? rel : alloc;
            if (cur.valid) begin
                if (cur.is_release) begin
                    free_next[cur.bank] = free_next[cur.bank] + space_t'(cur.length);
                    // count saturates at zero
                    if (cnt_next[cur.bank][cur.port] != '0) begin
                        cnt_next[cur.bank][cur.port] = cnt_next[cur.bank][cur.port] - 1'b1;
                    end
                end else begin
                    free_next[cur.bank] = free_next[cur.bank] - space_t'(cur.length);
                    cnt_next[cur.bank][cur.port] = cnt_next[cur.bank][cur.port] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                free_space[b] <= space_t'(BANK_WORDS);
                for (int p = 0; p < NUM_PORTS; p++) begin
                    pkt_cnt[b][p] <= '0;
                end
            end
        end else begin
            free_space <= free_next;
            pkt_cnt    <= cnt_next;
        end
    end

    // read takes the post-update value, an update in the read cycle is visible
    always_ff @(posedge clk) begin
        rd_status.free_space    <= free_next[rd_bank];
        rd_status.packet_amount <= cnt_next[rd_bank][rd_port];
    end

endmodule

// File: logic/port_wr_sram_matcher.sv
`timescale 1ns/1ps

module port_wr_sram_matcher
    import sram_alloc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  match_req_t           req_data,
    input  logic                 req_empty,
    output logic                 req_pop,
    output logic                 res_push,
    output match_result_t        res_data,
    input  logic                 res_full,
    input  logic [NUM_BANKS-1:0] lock_mask,
    output bank_idx_t            rd_bank,
    output port_idx_t            rd_port,
    input  bank_status_t         rd_status,
    output bank_update_t         alloc
);

    typedef enum logic [1:0] {IDLE, CHECK, SCAN, DONE} state_t;

    state_t        state;
    match_req_t    req_q;
    match_result_t res_q;
    logic          last_valid;
    port_idx_t     last_port;
    bank_idx_t     last_bank;
    logic [5:0]    iss_idx;
    logic [5:0]    iss_sel;
    logic [5:0]    exam_cnt;
    logic [5:0]    exam_now;
    logic [5:0]    cand_num;
    logic [4:0]    thr_min;
    bank_idx_t     rsp_bank;
    bank_idx_t     best_bank;
    bank_idx_t     best_now;
    pkt_cnt_t      best_cnt;
    logic          found_q;
    logic          found_now;
    logic          qualify;
    logic          take;
    logic          fast_ok;
    logic          scan_end;

    // semi mode of ports 8..15 visits its own pair twice, a repeat never wins a tie
    function automatic bank_idx_t cand_bank(match_mode_t mode, port_idx_t port,
                                            logic [5:0] idx);
        bank_idx_t bank;
        case (mode)
            MODE_STATIC: bank = {port, idx[0]};
            MODE_SEMI: begin
                if (idx < 6'd2) bank = {port, idx[0]};
                else            bank = bank_idx_t'(idx + 6'd14);
            end
            default: bank = bank_idx_t'(idx);
        endcase
        return bank;
    endfunction

    function automatic logic [5:0] cand_count(match_mode_t mode);
        case (mode)
            MODE_STATIC: return 6'd2;
            MODE_SEMI:   return 6'd18;
            default:     return 6'd32;
        endcase
    endfunction

    always_comb begin
        cand_num  = cand_count(req_q.mode);
        iss_sel   = (iss_idx < cand_num) ? iss_idx : 6'd0;
        // rd_status holds the candidate issued in the previous cycle
        qualify   = !lock_mask[rsp_bank] &&
                    (rd_status.free_space >= space_t'(req_q.length));
        take      = qualify && (!found_q || (rd_status.packet_amount > best_cnt));
        found_now = found_q | qualify;
        best_now  = take ? rsp_bank : best_bank;
        exam_now  = exam_cnt + 6'd1;
        thr_min   = (req_q.threshold == '0) ? 5'd1 : req_q.threshold;
        scan_end  = (found_now && (exam_now >= {1'b0, thr_min})) || (exam_now >= cand_num);
        fast_ok   = last_valid && (req_q.dest_port == last_port) && !lock_mask[last_bank] &&
                    (rd_status.free_space >= space_t'(req_q.length));
    end

    always_comb begin
        case (state)
            IDLE: begin
                // head of the request FIFO, read as it is popped
                rd_bank = last_bank;
                rd_port = req_data.dest_port;
            end
            CHECK: begin
                rd_bank = cand_bank(req_q.mode, req_q.dest_port, 6'd0);
                rd_port = req_q.dest_port;
            end
            default: begin
                rd_bank = cand_bank(req_q.mode, req_q.dest_port, iss_sel);
                rd_port = req_q.dest_port;
            end
        endcase
    end

    assign req_pop  = (state == IDLE) && !req_empty;
    assign res_push = (state == DONE) && !res_full;
    assign res_data = res_q;
    assign alloc    = '{valid:      res_push && res_q.found,
                        is_release: 1'b0,
                        bank:       res_q.bank,
                        port:       res_q.dest_port,
                        length:     req_q.length};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            last_valid <= 1'b0;
            last_port  <= '0;
            last_bank  <= '0;
        end else begin
            case (state)
                IDLE:  if (req_pop) state <= CHECK;
                CHECK: state <= fast_ok ? DONE : SCAN;
                SCAN:  if (scan_end) state <= DONE;
                DONE: begin
                    // result held here while the result FIFO is full
                    if (res_push) begin
                        state <= IDLE;
                        if (res_q.found) begin
                            last_valid <= 1'b1;
                            last_port  <= res_q.dest_port;
                            last_bank  <= res_q.bank;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: if (req_pop) req_q <= req_data;
            CHECK: begin
                // candidate 0 goes out now so the scan loses no cycle
                iss_idx   <= 6'd1;
                rsp_bank  <= rd_bank;
                exam_cnt  <= '0;
                found_q   <= 1'b0;
                best_bank <= '0;
                best_cnt  <= '0;
                if (fast_ok) begin
                    res_q <= '{found: 1'b1, fast: 1'b1, bank: last_bank,
                               dest_port: req_q.dest_port};
                end
            end
            SCAN: begin
                if (iss_idx < cand_num) iss_idx <= iss_idx + 6'd1;
                rsp_bank  <= rd_bank;
                exam_cnt  <= exam_now;
                found_q   <= found_now;
                best_bank <= best_now;
                if (take) best_cnt <= rd_status.packet_amount;
                if (scan_end) begin
                    res_q <= '{found: found_now, fast: 1'b0,
                               bank: found_now ? best_now : bank_idx_t'(0),
                               dest_port: req_q.dest_port};
                end
            end
            default: ;
        endcase
    end

endmodule

// File: logic/apb_alloc_regs.sv
`timescale 1ns/1ps

module apb_alloc_regs
    import sram_alloc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  apb_addr_t            paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 req_push,
    output match_req_t           req_data,
    input  logic                 req_full,
    input  logic                 req_empty,
    output logic                 res_pop,
    input  match_result_t        res_data,
    input  logic                 res_empty,
    output bank_update_t         rel,
    output logic [NUM_BANKS-1:0] lock_mask
);

    logic        wr_en;
    logic        rd_en;
    match_mode_t ctrl_mode;
    logic [4:0]  ctrl_thr;
    logic        ovf_q;

    // no wait states, so every access phase completes at its edge
    assign wr_en = psel & penable & pwrite;
    assign rd_en = psel & penable & ~pwrite;

    assign req_push = wr_en && (paddr == REG_REQ) && !req_full;
    assign req_data = '{dest_port: pwdata[19:16],
                        length:    pwdata[8:0],
                        mode:      ctrl_mode,
                        threshold: ctrl_thr};

    // an empty result FIFO reads as valid = 0 and is left alone
    assign res_pop = rd_en && (paddr == REG_RESULT) && !res_empty;

    assign rel = '{valid:      wr_en && (paddr == REG_RELEASE),
                   is_release: 1'b1,
                   bank:       pwdata[28:24],
                   port:       pwdata[19:16],
                   length:     pwdata[8:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_mode <= MODE_DYNAMIC;
            ctrl_thr  <= '0;
            lock_mask <= '0;
            ovf_q     <= 1'b0;
        end else if (wr_en) begin
            case (paddr)
                REG_CTRL: begin
                    ctrl_mode <= match_mode_t'(pwdata[1:0]);
                    ctrl_thr  <= pwdata[12:8];
                end
                REG_LOCK:   lock_mask <= pwdata;
                REG_STATUS: ovf_q <= 1'b0;
                // request dropped on a full FIFO, remembered until cleared
                REG_REQ:    if (req_full) ovf_q <= 1'b1;
                default: ;
            endcase
        end
    end

    always_comb begin
        prdata = '0;
        if (rd_en) begin
            case (paddr)
                REG_CTRL:   prdata = {19'd0, ctrl_thr, 6'd0, ctrl_mode};
                REG_LOCK:   prdata = lock_mask;
                REG_RESULT: begin
                    if (!res_empty) begin
                        prdata = {1'b1, res_data.found, res_data.fast, 17'd0,
                                  res_data.dest_port, 3'd0, res_data.bank};
                    end
                end
                REG_STATUS: prdata = {30'd0, req_empty, ovf_q};
                default: ;
            endcase
        end
    end

endmodule

// File: logic/sram_alloc_top.sv
`timescale 1ns/1ps

module sram_alloc_top
    import sram_alloc_pkg::*;
#(
    parameter int FIFO_DEPTH = sram_alloc_pkg::FIFO_DEPTH
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata
);

    logic                 req_push;
    match_req_t           req_push_data;
    logic                 req_full;
    logic                 req_pop;
    match_req_t           req_head;
    logic                 req_empty;
    logic                 res_push;
    match_result_t        res_push_data;
    logic                 res_full;
    logic                 res_pop;
    match_result_t        res_head;
    logic                 res_empty;
    bank_update_t         rel;
    bank_update_t         alloc;
    logic [NUM_BANKS-1:0] lock_mask;
    bank_idx_t            rd_bank;
    port_idx_t            rd_port;
    bank_status_t         rd_status;

    apb_alloc_regs apb_alloc_regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .req_push  (req_push),
        .req_data  (req_push_data),
        .req_full  (req_full),
        .req_empty (req_empty),
        .res_pop   (res_pop),
        .res_data  (res_head),
        .res_empty (res_empty),
        .rel       (rel),
        .lock_mask (lock_mask)
    );

    desc_fifo #(
        .payload_t (match_req_t),
        .DEPTH     (FIFO_DEPTH)
    ) req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (req_push),
        .push_data (req_push_data),
        .full      (req_full),
        .pop       (req_pop),
        .pop_data  (req_head),
        .empty     (req_empty)
    );

    desc_fifo #(
        .payload_t (match_result_t),
        .DEPTH     (FIFO_DEPTH)
    ) res_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (res_push),
        .push_data (res_push_data),
        .full      (res_full),
        .pop       (res_pop),
        .pop_data  (res_head),
        .empty     (res_empty)
    );

    bank_status_table bank_status_table_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_bank   (rd_bank),
        .rd_port   (rd_port),
        .rd_status (rd_status),
        .alloc     (alloc),
        .rel       (rel)
    );

    port_wr_sram_matcher port_wr_sram_matcher_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_data  (req_head),
        .req_empty (req_empty),
        .req_pop   (req_pop),
        .res_push  (res_push),
        .res_data  (res_push_data),
        .res_full  (res_full),
        .lock_mask (lock_mask),
        .rd_bank   (rd_bank),
        .rd_port   (rd_port),
        .rd_status (rd_status),
        .alloc     (alloc)
    );

endmodule

// File: verif/sram_alloc_properties.sv
`timescale 1ns/1ps

module sram_alloc_properties
    import sram_alloc_pkg::*;
(
    input logic          clk,
    input logic          rst_n,
    input logic [1:0]    state,
    input match_req_t    req_q,
    input bank_idx_t     rd_bank,
    input logic          res_full,
    input match_result_t res_data,
    input bank_update_t  alloc
);

    // candidate set of a mode for the port of the request
    function automatic logic in_cand_set(match_mode_t mode, port_idx_t port,
                                         bank_idx_t bank);
        case (mode)
            MODE_STATIC: return (bank[4:1] == port);
            MODE_SEMI:   return (bank[4:1] == port) || bank[4];
            default:     return 1'b1;
        endcase
    endfunction

    // a finished result waits unchanged while the result FIFO is full
    a_hold_on_full: assert property (@(posedge clk) disable iff (!rst_n)
        (state == 2'd3 && res_full) |=> (state == 2'd3 && $stable(res_data)))
        else $error("result not held while the result FIFO is full");

    // IDLE reads the last bank and is left out
    a_rd_bank_in_set: assert property (@(posedge clk) disable iff (!rst_n)
        (state == 2'd1 || state == 2'd2) |->
            in_cand_set(req_q.mode, req_q.dest_port, rd_bank))
        else $error("read bank outside the candidate set of the mode");

    // a scanned allocation stays inside the candidate set
    a_alloc_in_set: assert property (@(posedge clk) disable iff (!rst_n)
        (alloc.valid && !res_data.fast) |->
            in_cand_set(req_q.mode, req_q.dest_port, alloc.bank))
        else $error("allocation outside the candidate set of the mode");

endmodule

bind port_wr_sram_matcher sram_alloc_properties sram_alloc_properties_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .req_q     (req_q),
    .rd_bank   (rd_bank),
    .res_full  (res_full),
    .res_data  (res_data),
    .alloc     (alloc)
);

// File: verif/sram_alloc_checker.sv
`timescale 1ns/1ps

module sram_alloc_checker
    import sram_alloc_pkg::*;
(
    input logic        clk,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input apb_addr_t   paddr,
    input logic [31:0] prdata
);

    logic [31:0] exp_q [$];
    logic [31:0] exp_val;
    string       test_name = "none";
    int          err_count = 0;
    int          check_count = 0;

    task automatic set_test(input string name);
        test_name = name;
    endtask

    // RESULT layout: valid, found, fast, dest_port [11:8], bank [4:0]
    task automatic expect_result(input match_result_t r);
        exp_q.push_back({1'b1, r.found, r.fast, 17'd0, r.dest_port, 3'd0, r.bank});
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        err_count++;
        $display("%s", msg);
    endtask

    // access phase is stable at the falling edge, the pop happens at the next rising edge
    always @(negedge clk) begin
        if (psel && penable && !pwrite && paddr == REG_RESULT) begin
            // empty result FIFO reads as all zero
            exp_val = (exp_q.size() != 0) ? exp_q.pop_front() : 32'd0;
            check_value(test_name, exp_val, prdata);
        end
    end

    task automatic print_summary();
        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d expected results were never read back",
                                     exp_q.size()));
        end
        $display("checks %0d errors %0d", check_count, err_count);
    endtask

endmodule

// File: verif/sram_alloc_tb.sv
`timescale 1ns/1ps

module sram_alloc_tb
    import sram_alloc_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;

    // shadow of the bank table and matcher state
    int          free_tab [NUM_BANKS];
    int          cnt_tab  [NUM_BANKS][NUM_PORTS];
    logic [31:0] lock_cur;
    match_mode_t mode_cur;
    int          thr_cur;
    bit          last_valid;
    int          last_port;
    int          last_bank;
    int          posted;
    int          cycles;
    logic [31:0] lfsr_state;

    sram_alloc_top #(.FIFO_DEPTH(FIFO_DEPTH)) sram_alloc_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata)
    );

    sram_alloc_checker sram_alloc_checker_inst (
        .clk     (clk),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .prdata  (prdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // limit grows with every posted request
    always @(posedge clk) begin
        cycles++;
        if (cycles > 200 * posted + 500) begin
            $display("timeout after %0d cycles with %0d requests posted", cycles, posted);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2 penable = 1'b1;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #2 penable = 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // fast path before the scan and its stop rule
    function automatic match_result_t ref_match(input int port, input int len);
        match_result_t r;
        int            cand [$];
        int            thr_min;
        int            best_cnt;
        int            b;
        r = '0;
        r.dest_port = port_idx_t'(port);
        if (last_valid && last_port == port && !lock_cur[last_bank] &&
            free_tab[last_bank] >= len) begin
            r.found = 1'b1;
            r.fast  = 1'b1;
            r.bank  = bank_idx_t'(last_bank);
            return r;
        end
        if (mode_cur != MODE_DYNAMIC) begin
            cand.push_back(2 * port);
            cand.push_back(2 * port + 1);
        end
        if (mode_cur == MODE_SEMI) begin
            for (int i = 16; i < NUM_BANKS; i++) cand.push_back(i);
        end
        if (mode_cur == MODE_DYNAMIC) begin
            for (int i = 0; i < NUM_BANKS; i++) cand.push_back(i);
        end
        thr_min  = (thr_cur == 0) ? 1 : thr_cur;
        best_cnt = 0;
        foreach (cand[k]) begin
            b = cand[k];
            if (!lock_cur[b] && free_tab[b] >= len &&
                (!r.found || cnt_tab[b][port] > best_cnt)) begin
                r.found  = 1'b1;
                r.bank   = bank_idx_t'(b);
                best_cnt = cnt_tab[b][port];
            end
            if (r.found && k + 1 >= thr_min) break;
        end
        return r;
    endfunction

    task automatic set_ctrl(input match_mode_t mode, input int thr);
        apb_write(REG_CTRL, {19'd0, 5'(thr), 6'd0, mode});
        mode_cur = mode;
        thr_cur  = thr;
    endtask

    task automatic set_lock(input logic [31:0] mask);
        apb_write(REG_LOCK, mask);
        lock_cur = mask;
    endtask

    task automatic release_bank(input int bank, input int port, input int len);
        apb_write(REG_RELEASE, {3'd0, 5'(bank), 4'd0, 4'(port), 7'd0, 9'(len)});
        free_tab[bank] += len;
        if (cnt_tab[bank][port] > 0) cnt_tab[bank][port]--;
    endtask

    task automatic post_req(input int port, input int len, input bit accepted);
        match_result_t r;
        apb_write(REG_REQ, {12'd0, 4'(port), 7'd0, 9'(len)});
        posted++;
        if (accepted) begin
            r = ref_match(port, len);
            sram_alloc_checker_inst.expect_result(r);
            if (r.found) begin
                free_tab[r.bank] -= len;
                cnt_tab[r.bank][port]++;
                last_valid = 1'b1;
                last_port  = port;
                last_bank  = r.bank;
            end
        end
    endtask

    task automatic read_result();
        logic [31:0] d;
        while (sram_alloc_top_inst.res_empty) @(negedge clk);
        apb_read(REG_RESULT, d);
    endtask

    // the last accepted result sits in the matcher behind a full result FIFO
    task automatic wait_held_result();
        while (!(sram_alloc_top_inst.res_full &&
                 sram_alloc_top_inst.port_wr_sram_matcher_inst.state == 2'd3)) begin
            @(negedge clk);
        end
    endtask

    task automatic request(input int port, input int len);
        post_req(port, len, 1'b1);
        read_result();
    endtask

    initial begin
        logic [31:0] d;
        logic [31:0] rnd;
        int          port;
        int          len;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        rst_n      = 1'b0;
        lfsr_state = 32'd32220;
        lock_cur   = '0;
        mode_cur   = MODE_DYNAMIC;
        thr_cur    = 0;
        last_valid = 1'b0;
        last_port  = 0;
        last_bank  = 0;
        posted     = 0;
        cycles     = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            free_tab[b] = BANK_WORDS;
            for (int p = 0; p < NUM_PORTS; p++) cnt_tab[b][p] = 0;
        end
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;

        sram_alloc_checker_inst.set_test("reset");
        apb_read(REG_CTRL, d);
        sram_alloc_checker_inst.check_value("reset ctrl", 32'h2, d);
        apb_read(REG_LOCK, d);
        sram_alloc_checker_inst.check_value("reset lock", 32'h0, d);

        // counts on the own pair come from allocations and releases
        sram_alloc_checker_inst.set_test("static");
        set_ctrl(MODE_STATIC, 2);
        request(3, 100);
        request(5, 100);
        set_lock(32'h1 << 6);
        request(3, 60);
        set_lock(32'h0);
        request(5, 40);
        request(3, 40);
        release_bank(6, 3, 100);
        request(5, 30);
        request(3, 30);
        // bank 6 drains below bank 7 and the last release hits the zero floor
        release_bank(6, 3, 40);
        release_bank(6, 3, 30);
        release_bank(6, 3, 0);
        request(5, 20);
        request(3, 20);

        sram_alloc_checker_inst.set_test("dynamic");
        set_ctrl(MODE_DYNAMIC, 31);
        for (int i = 0; i < 12; i++) begin
            take_bits(4, rnd);
            port = rnd;
            take_bits(9, rnd);
            len = rnd;
            request(port, len);
        end

        sram_alloc_checker_inst.set_test("semi");
        set_ctrl(MODE_SEMI, 3);
        for (int i = 0; i < 10; i++) begin
            take_bits(32, rnd);
            set_lock(rnd);
            take_bits(4, rnd);
            port = rnd;
            take_bits(9, rnd);
            len = rnd;
            request(port, len);
        end

        sram_alloc_checker_inst.set_test("fast");
        set_lock(32'h0);
        set_ctrl(MODE_DYNAMIC, 1);
        request(9, 20);
        request(9, 20);
        request(2, 20);
        request(9, 20);

        sram_alloc_checker_inst.set_test("nofit");
        set_lock(32'hFFFF_FFFF);
        request(4, 10);
        set_ctrl(MODE_STATIC, 0);
        set_lock(32'h3 << 8);
        request(4, 10);
        set_lock(32'h0);
        request(4, 10);

        // each scan is slow and the sixth post finds the request FIFO full
        sram_alloc_checker_inst.set_test("overflow");
        set_ctrl(MODE_DYNAMIC, 31);
        for (int i = 0; i < 6; i++) post_req(10 + i, 8, i < FIFO_DEPTH + 1);
        apb_read(REG_STATUS, d);
        sram_alloc_checker_inst.check_value("overflow status", 32'h1, d);
        apb_write(REG_STATUS, 32'h0);
        wait_held_result();
        for (int i = 0; i < FIFO_DEPTH + 1; i++) read_result();
        apb_read(REG_STATUS, d);
        sram_alloc_checker_inst.check_value("overflow cleared", 32'h2, d);
        apb_read(REG_RESULT, d);

        sram_alloc_checker_inst.print_summary();
        if (sram_alloc_checker_inst.err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: compile.f
logic/sram_alloc_pkg.sv
logic/desc_fifo.sv
logic/bank_status_table.sv
logic/port_wr_sram_matcher.sv
logic/apb_alloc_regs.sv
logic/sram_alloc_top.sv
verif/sram_alloc_properties.sv
verif/sram_alloc_checker.sv
verif/sram_alloc_tb.sv

// File: run.sh
#!/bin/sh
# build the simulation with Verilator and run it
# the run passes only if the pass message shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module sram_alloc_tb -o sim_sram_alloc &&
./obj_dir/sim_sram_alloc | tee /dev/stderr | grep -q "All checks passed" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
